// File: src/gbufPkg.sv
/* Activation buffer geometry */

package gbufPkg;

    // ========================================
    // Buffer geometry defaults
    // ========================================

    // Byte address into the global activation buffer
    // 8 bits give 256 bytes of storage
    parameter int AddrWidthDef = 8;

    // One activation element per buffer entry
    parameter int DataWidthDef = 8;        // Byte wide

endpackage

// File: src/packerPkg.sv
/* Lane packer defaults and state */

package packerPkg;

    // ========================================
    // Packing geometry
    // ========================================

    parameter int NumDataDef  = 4;         // Bytes per packed word
    parameter int NumLanesDef = 4;         // PE lanes fed by the reader

    // ========================================
    // Packer FSM encoding
    // ========================================

    // Read is the request level seen by the reader
    typedef enum logic {
        Idle = 1'b0,                       // Waiting for a start pulse
        Read = 1'b1                        // Fetching bytes from the buffer
    } packState_t;

endpackage

// File: src/gbufReader.sv
/* Global buffer reader, round robin */

`timescale 1ns/1ps

module gbufReader #(
    parameter int NumLanes  = packerPkg::NumLanesDef,
    parameter int DataWidth = gbufPkg::DataWidthDef,
    parameter int AddrWidth = gbufPkg::AddrWidthDef,
    localparam int LaneW    = (NumLanes > 1) ? $clog2(NumLanes) : 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          WrEn,      // Host write strobe
    input  logic [AddrWidth-1:0]          WrAddr,
    input  logic [DataWidth-1:0]          WrData,
    input  logic [NumLanes-1:0]           Sta,       // Per-lane start pulse
    input  logic [NumLanes*AddrWidth-1:0] BaseAddr,  // Lane 0 in low slice
    input  logic [NumLanes-1:0]           ReqDat,    // Packer request levels
    output logic [NumLanes-1:0]           ValDat,    // One-hot, one clk after grant
    output logic [DataWidth-1:0]          Dat        // Shared return bus
);

    // ========================================
    // Storage and lane state
    // ========================================

    logic [DataWidth-1:0] mem [2**AddrWidth];       // Activation bytes
    logic [AddrWidth-1:0] laneAddr [NumLanes];      // Next byte per lane
    logic [AddrWidth-1:0] curAddr [NumLanes];       // Address used this cycle
    logic [LaneW-1:0]     rrPtr;                    // Last granted lane

    logic                 grantValid;
    logic [LaneW-1:0]     grantIdx;
    logic [NumLanes-1:0]  grantHot;

    // Host write port
    always_ff @(posedge clk) begin
        if (WrEn) begin
            mem[WrAddr] <= WrData;
        end
    end

    // Start cycle may already be granted, so bypass the base address
    always_comb begin
        for (int i = 0; i < NumLanes; i++) begin
            curAddr[i] = Sta[i] ? BaseAddr[i*AddrWidth +: AddrWidth] : laneAddr[i];
        end
    end

    // ========================================
    // Round-robin grant
    // ========================================

    // Search starts at the lane after the last grant
    always_comb begin
        int cand;
        grantValid = 1'b0;
        grantIdx   = '0;
        grantHot   = '0;
        for (int k = 1; k <= NumLanes; k++) begin
            cand = (int'(rrPtr) + k) % NumLanes;
            if (!grantValid && ReqDat[cand]) begin
                grantValid     = 1'b1;
                grantIdx       = LaneW'(cand);
                grantHot[cand] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rrPtr  <= LaneW'(NumLanes - 1);         // Lane 0 wins first
            ValDat <= '0;
        end else begin
            ValDat <= grantHot;                     // Lags grant by one clk
            if (grantValid) begin
                rrPtr <= grantIdx;
            end
        end
    end

    // Per-lane address counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NumLanes; i++) begin
                laneAddr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumLanes; i++) begin
                if (grantHot[i]) begin
                    laneAddr[i] <= curAddr[i] + 1'b1;   // Wraps at buffer end
                end else if (Sta[i]) begin
                    laneAddr[i] <= curAddr[i];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (grantValid) begin
            Dat <= mem[curAddr[grantIdx]];
        end
    end

endmodule

// File: src/packer.sv
/* Lane packer */

`timescale 1ns/1ps

module packer #(
    parameter int NumData   = packerPkg::NumDataDef,
    parameter int DataWidth = gbufPkg::DataWidthDef,
    localparam int CntW     = $clog2(NumData) + 1,
    localparam int WordW    = NumData * DataWidth
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [CntW-1:0]      NumPacker,      // 1 to NumData bytes
    input  logic                 Sta,            // Start pulse
    input  logic                 Bypass,         // Zero-count start
    input  logic                 ValDat,         // Byte on Dat this cycle
    input  logic [DataWidth-1:0] Dat,
    output logic                 ReqDat,         // Next-state request level
    output logic [WordW-1:0]     DatPacker,
    output logic                 NearFnhPacker   // Word final next cycle
);

    // ========================================
    // FSM
    // ========================================

    packerPkg::packState_t state;
    packerPkg::packState_t nextState;

    logic [CntW-1:0] cntFetch;                   // Bytes received so far
    logic [CntW-1:0] lastIdx;

    always_comb begin
        nextState = state;
        case (state)
            packerPkg::Idle: begin
                if (Sta && !Bypass) begin
                    nextState = packerPkg::Read;
                end
            end
            packerPkg::Read: begin
                if (NearFnhPacker) begin
                    nextState = packerPkg::Idle;  // Drop request on last byte
                end
            end
            default: nextState = packerPkg::Idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= packerPkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    assign ReqDat = (nextState == packerPkg::Read);

    // ========================================
    // Fetch count and finish
    // ========================================

    assign lastIdx = NumPacker - 1'b1;

    // Bypass with zero count finishes without a read
    assign NearFnhPacker = (Sta && Bypass && (NumPacker == '0))
                        || (ValDat && (cntFetch == lastIdx));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cntFetch <= '0;
        end else if (NearFnhPacker) begin
            cntFetch <= '0;
        end else if (ValDat) begin
            cntFetch <= cntFetch + 1'b1;
        end
    end

    // Shift in at the low end, first byte drifts up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            DatPacker <= '0;
        end else if (Sta) begin
            DatPacker <= '0;                     // Upper bytes stay zero
        end else if (ValDat) begin
            DatPacker <= (DatPacker << DataWidth) | WordW'(Dat);
        end
    end

endmodule

// File: src/packResultCollector.sv
/* Packed word result collector */

`timescale 1ns/1ps

module packResultCollector #(
    parameter int NumLanes  = packerPkg::NumLanesDef,
    parameter int NumData   = packerPkg::NumDataDef,
    parameter int DataWidth = gbufPkg::DataWidthDef,
    localparam int LaneW    = (NumLanes > 1) ? $clog2(NumLanes) : 1,
    localparam int WordW    = NumData * DataWidth
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [NumLanes-1:0]       NearFnhPacker,  // Per-lane finish pulse
    input  logic [NumLanes*WordW-1:0] DatPacker,      // Lane 0 in low slice
    output logic                      ResultValid,    // One-cycle pulse
    output logic [LaneW-1:0]          ResultLane,
    output logic [WordW-1:0]          ResultData
);

    // ========================================
    // Capture
    // ========================================

    logic [NumLanes-1:0] finDly;                  // Word final this cycle
    logic [NumLanes-1:0] pending;
    logic [WordW-1:0]    slot [NumLanes];

    logic                pickValid;
    logic [LaneW-1:0]    pickIdx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finDly <= '0;
        end else begin
            finDly <= NearFnhPacker;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NumLanes; i++) begin
            if (finDly[i]) begin
                slot[i] <= DatPacker[i*WordW +: WordW];
            end
        end
    end

    // ========================================
    // Emit lowest pending lane
    // ========================================

    // Descending scan leaves the lowest pending index
    always_comb begin
        pickValid = 1'b0;
        pickIdx   = '0;
        for (int i = NumLanes - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pickValid = 1'b1;
                pickIdx   = LaneW'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending     <= '0;
            ResultValid <= 1'b0;
        end else begin
            for (int i = 0; i < NumLanes; i++) begin
                if (finDly[i]) begin
                    pending[i] <= 1'b1;
                end else if (pickValid && (pickIdx == LaneW'(i))) begin
                    pending[i] <= 1'b0;    // Emitted this cycle
                end
            end
            ResultValid <= pickValid;
        end
    end

    always_ff @(posedge clk) begin
        if (pickValid) begin
            ResultLane <= pickIdx;
            ResultData <= slot[pickIdx];
        end
    end

endmodule

// File: src/actPackTop.sv
/* Activation fetch and pack top */

`timescale 1ns/1ps

module actPackTop #(
    parameter int NumLanes  = packerPkg::NumLanesDef,
    parameter int NumData   = packerPkg::NumDataDef,
    parameter int DataWidth = gbufPkg::DataWidthDef,
    parameter int AddrWidth = gbufPkg::AddrWidthDef,
    localparam int LaneW    = (NumLanes > 1) ? $clog2(NumLanes) : 1,
    localparam int CntW     = $clog2(NumData) + 1,
    localparam int WordW    = NumData * DataWidth
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          WrEn,       // Buffer preload
    input  logic [AddrWidth-1:0]          WrAddr,
    input  logic [DataWidth-1:0]          WrData,
    input  logic [NumLanes-1:0]           Sta,        // Per-lane start pulse
    input  logic [NumLanes-1:0]           Bypass,
    input  logic [NumLanes*CntW-1:0]      NumPacker,  // Lane 0 in low slice
    input  logic [NumLanes*AddrWidth-1:0] BaseAddr,
    output logic                          ResultValid,
    output logic [LaneW-1:0]              ResultLane,
    output logic [WordW-1:0]              ResultData
);

    // ========================================
    // Inter-block wires
    // ========================================

    logic [NumLanes-1:0]       reqDat;
    logic [NumLanes-1:0]       valDat;
    logic [DataWidth-1:0]      dat;               // Shared return bus
    logic [NumLanes-1:0]       nearFnh;
    logic [NumLanes*WordW-1:0] datPacker;

    gbufReader #(
        .NumLanes  (NumLanes),
        .DataWidth (DataWidth),
        .AddrWidth (AddrWidth)
    ) i_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .WrEn     (WrEn),
        .WrAddr   (WrAddr),
        .WrData   (WrData),
        .Sta      (Sta),
        .BaseAddr (BaseAddr),
        .ReqDat   (reqDat),
        .ValDat   (valDat),
        .Dat      (dat)
    );

    // One packer per PE lane
    for (genvar g = 0; g < NumLanes; g++) begin : genLane
        packer #(
            .NumData   (NumData),
            .DataWidth (DataWidth)
        ) i_packer (
            .clk           (clk),
            .rst_n         (rst_n),
            .NumPacker     (NumPacker[g*CntW +: CntW]),
            .Sta           (Sta[g]),
            .Bypass        (Bypass[g]),
            .ValDat        (valDat[g]),
            .Dat           (dat),
            .ReqDat        (reqDat[g]),
            .DatPacker     (datPacker[g*WordW +: WordW]),
            .NearFnhPacker (nearFnh[g])
        );
    end

    packResultCollector #(
        .NumLanes  (NumLanes),
        .NumData   (NumData),
        .DataWidth (DataWidth)
    ) i_collector (
        .clk           (clk),
        .rst_n         (rst_n),
        .NearFnhPacker (nearFnh),
        .DatPacker     (datPacker),
        .ResultValid   (ResultValid),
        .ResultLane    (ResultLane),
        .ResultData    (ResultData)
    );

endmodule

// File: include/tbVectors.svh
/* Packer test vectors */

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// ========================================
// Test table
// ========================================

localparam int NumTests = 7;

// One entry per test, applied in order
localparam string TestName [NumTests] = '{
    "full4",         // Single lane, full word
    "short1",        // One byte in the low end
    "short2",        // Two bytes, upper zero
    "bypass",        // Zero count on a lane holding an old word
    "allLanes",      // Four lanes at once
    "restart",       // Lane 0 again, shorter word
    "wrap"           // Address runs past the buffer end
};

// Lanes started by each test
localparam logic [3:0] TestLanes [NumTests] = '{
    4'b0001, 4'b0010, 4'b0100, 4'b0100, 4'b1111, 4'b0001, 4'b0010
};

// Lane k of a multi-lane test starts at StartAddr + 8*k
localparam logic [7:0] TestAddr [NumTests] = '{
    8'h10, 8'h20, 8'h30, 8'h00, 8'h40, 8'h50, 8'hfe
};

localparam logic [2:0] TestCount [NumTests] = '{
    3'd4, 3'd1, 3'd2, 3'd0, 3'd4, 3'd2, 3'd4
};

localparam logic TestBypass [NumTests] = '{
    1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0
};

`endif

// File: test/tbActPack.sv
/* Activation packer testbench */

`timescale 1ns/1ps

module tbActPack;

    localparam int NumLanes  = packerPkg::NumLanesDef;
    localparam int NumData   = packerPkg::NumDataDef;
    localparam int DataWidth = gbufPkg::DataWidthDef;
    localparam int AddrWidth = gbufPkg::AddrWidthDef;
    localparam int LaneW     = (NumLanes > 1) ? $clog2(NumLanes) : 1;
    localparam int CntW      = $clog2(NumData) + 1;
    localparam int WordW     = NumData * DataWidth;
    localparam int WaitLimit = 200;              // Cycles per result

    `include "tbVectors.svh"

    logic                          clk;
    logic                          rst_n;
    logic                          WrEn;
    logic [AddrWidth-1:0]          WrAddr;
    logic [DataWidth-1:0]          WrData;
    logic [NumLanes-1:0]           Sta;
    logic [NumLanes-1:0]           Bypass;
    logic [NumLanes*CntW-1:0]      NumPacker;
    logic [NumLanes*AddrWidth-1:0] BaseAddr;
    logic                          ResultValid;
    logic [LaneW-1:0]              ResultLane;
    logic [WordW-1:0]              ResultData;

    logic [DataWidth-1:0] gold [2**AddrWidth];   // Copy of buffer contents
    logic [WordW-1:0]     expected [NumLanes];   // Reference word per lane
    logic [31:0]          lfsr;
    int                   errCount;
    int                   checkCount;
    int                   testFails;

    actPackTop #(
        .NumLanes  (NumLanes),
        .NumData   (NumData),
        .DataWidth (DataWidth),
        .AddrWidth (AddrWidth)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .WrEn        (WrEn),
        .WrAddr      (WrAddr),
        .WrData      (WrData),
        .Sta         (Sta),
        .Bypass      (Bypass),
        .NumPacker   (NumPacker),
        .BaseAddr    (BaseAddr),
        .ResultValid (ResultValid),
        .ResultLane  (ResultLane),
        .ResultData  (ResultData)
    );

    always #2 clk = ~clk;                        // 4 ns period

    // ========================================
    // Reference helpers
    // ========================================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    function automatic logic [DataWidth-1:0] randByte(inout logic [31:0] s);
        logic [DataWidth-1:0] v;
        v = '0;
        for (int b = 0; b < DataWidth; b++) begin
            s = lfsrStep(s);
            v = {v[DataWidth-2:0], s[0]};
        end
        return v;
    endfunction

    // Only multi-lane rows spread their lanes apart
    function automatic logic [AddrWidth-1:0] laneStart(input int t, input int k);
        if ($countones(TestLanes[t]) > 1) begin
            return TestAddr[t] + AddrWidth'(8 * k);
        end
        return TestAddr[t];
    endfunction

    // First fetched byte ends up highest in the low count bytes
    function automatic logic [WordW-1:0] expWord(input logic [AddrWidth-1:0] addr,
                                                 input int count, input logic byp);
        logic [WordW-1:0]     w;
        logic [AddrWidth-1:0] a;
        w = '0;
        if (byp) begin
            return '0;                           // No buffer read at all
        end
        // Fetch byte i sits at byte position count-1-i
        for (int i = 0; i < count; i++) begin
            a = addr + AddrWidth'(i);            // Buffer address wraps
            w[(count - 1 - i) * DataWidth +: DataWidth] = gold[a];
        end
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [WordW-1:0] exp,
                              input logic [WordW-1:0] act);
        checkCount++;
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errCount++;
        end
    endtask

    // ========================================
    // Stimulus and checking
    // ========================================

    initial begin
        int waited;
        int errBefore;
        int nLanes;
        logic [NumLanes-1:0] seen;

        clk        = 1'b0;
        rst_n      = 1'b0;
        WrEn       = 1'b0;
        WrAddr     = '0;
        WrData     = '0;
        Sta        = '0;
        Bypass     = '0;
        NumPacker  = '0;
        BaseAddr   = '0;
        lfsr       = 32'h8bd2b808;
        errCount   = 0;
        checkCount = 0;
        testFails  = 0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Fill every buffer byte and keep a copy
        for (int a = 0; a < 2**AddrWidth; a++) begin
            @(posedge clk);
            gold[a] = randByte(lfsr);
            WrEn   <= 1'b1;
            WrAddr <= AddrWidth'(a);
            WrData <= gold[a];
        end
        @(posedge clk);
        WrEn <= 1'b0;

        for (int t = 0; t < NumTests; t++) begin
            errBefore = errCount;
            seen      = '0;
            nLanes    = $countones(TestLanes[t]);
            @(posedge clk);
            for (int k = 0; k < NumLanes; k++) begin
                expected[k] = expWord(laneStart(t, k), TestCount[t], TestBypass[t]);
                BaseAddr[k*AddrWidth +: AddrWidth] <= laneStart(t, k);
                NumPacker[k*CntW +: CntW]          <= CntW'(TestCount[t]);
                Bypass[k]                          <= TestBypass[t];
            end
            Sta <= TestLanes[t];                 // One-cycle start pulse
            @(posedge clk);
            Sta <= '0;

            // One result per started lane in any order
            for (int got = 0; got < nLanes; got++) begin
                waited = 0;
                do begin
                    @(negedge clk);              // Outputs stable here
                    waited++;
                end while (!ResultValid && waited < WaitLimit);
                if (!ResultValid) begin
                    $display("Test %s: result never arrived within %0d cycles",
                             TestName[t], WaitLimit);
                    errCount++;
                    break;
                end
                if (!TestLanes[t][ResultLane] || seen[ResultLane]) begin
                    $display("Test %s: unexpected result from lane %0d",
                             TestName[t], ResultLane);
                    errCount++;
                end else begin
                    seen[ResultLane] = 1'b1;
                    checkValue(TestName[t], expected[ResultLane], ResultData);
                end
            end

            if (errCount == errBefore) begin
                $display("Test %s: ok", TestName[t]);
            end else begin
                testFails++;
                $display("Test %s: %0d errors", TestName[t], errCount - errBefore);
            end
        end

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 NumTests, testFails, checkCount, errCount);
        if (errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
src/gbufPkg.sv
src/packerPkg.sv
src/gbufReader.sv
src/packer.sv
src/packResultCollector.sv
src/actPackTop.sv
test/tbActPack.sv

// File: Bender.yml
package:
  name: act_pack

sources:
  # Packages first, then RTL bottom up
  - src/gbufPkg.sv
  - src/packerPkg.sv
  - src/gbufReader.sv
  - src/packer.sv
  - src/packResultCollector.sv
  - src/actPackTop.sv

  # Testbench with its stimulus table header
  - target: test
    include_dirs:
      - include
    files:
      - test/tbActPack.sv
